/* Bender.yml */
package:
  name: alu_iq

sources:
  - common/iq_pkg.sv
  - rtl/int_alu.sv
  - rtl/branch_unit.sv
  - rtl/exec_writeback.sv
  - alu_iq/iq_select.sv
  - alu_iq/alu_iq.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_alu_iq.sv

/* alu_iq/alu_iq.sv */
module alu_iq (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        flush_i,

    // dispatch
    input  logic                        disp_valid_i,
    input  iq_pkg::iq_op_e              disp_op_i,
    input  logic [iq_pkg::XLEN-1:0]     disp_pc_i,
    input  logic [iq_pkg::XLEN-1:0]     disp_imm_i,
    input  logic [iq_pkg::TAG_W-1:0]    disp_dst_tag_i,
    input  logic                        disp_src0_rdy_i,
    input  logic [iq_pkg::TAG_W-1:0]    disp_src0_tag_i,
    input  logic [iq_pkg::XLEN-1:0]     disp_src0_val_i,
    input  logic                        disp_src1_rdy_i,
    input  logic [iq_pkg::TAG_W-1:0]    disp_src1_tag_i,
    input  logic [iq_pkg::XLEN-1:0]     disp_src1_val_i,
    output logic                        iq_credit_o,

    // external writeback broadcast
    input  logic                        wb_valid_i,
    input  logic [iq_pkg::TAG_W-1:0]    wb_tag_i,
    input  logic [iq_pkg::XLEN-1:0]     wb_data_i,

    // result toward the downstream FIFO
    output logic                        result_valid_o,
    output logic [iq_pkg::TAG_W-1:0]    result_tag_o,
    output logic [iq_pkg::XLEN-1:0]     result_data_o,
    output logic                        redirect_o,
    output logic [iq_pkg::XLEN-1:0]     redirect_pc_o,
    input  logic                        fifo_credit_i
);
    import iq_pkg::*;

    logic             issue_allow;
    logic             ex_valid;
    iq_op_e           ex_op;
    logic [XLEN-1:0]  ex_pc;
    logic [XLEN-1:0]  ex_imm;
    logic [XLEN-1:0]  ex_a;
    logic [XLEN-1:0]  ex_b;
    logic [TAG_W-1:0] ex_tag;

    logic [XLEN-1:0]  alu_res;
    logic             br_taken;
    logic [XLEN-1:0]  br_target;
    logic [XLEN-1:0]  br_link;

    // the registered result doubles as the internal wakeup bus
    iq_select u_iq_select (
        .clk,
        .rst_n_i,
        .flush_i,
        .disp_valid_i,
        .disp_op_i,
        .disp_pc_i,
        .disp_imm_i,
        .disp_dst_tag_i,
        .disp_src0_rdy_i,
        .disp_src0_tag_i,
        .disp_src0_val_i,
        .disp_src1_rdy_i,
        .disp_src1_tag_i,
        .disp_src1_val_i,
        .wb_valid_i,
        .wb_tag_i,
        .wb_data_i,
        .fb_valid_i    (result_valid_o),
        .fb_tag_i      (result_tag_o),
        .fb_data_i     (result_data_o),
        .issue_allow_i (issue_allow),
        .iq_credit_o,
        .ex_valid_o    (ex_valid),
        .ex_op_o       (ex_op),
        .ex_pc_o       (ex_pc),
        .ex_imm_o      (ex_imm),
        .ex_a_o        (ex_a),
        .ex_b_o        (ex_b),
        .ex_tag_o      (ex_tag)
    );

    int_alu u_int_alu (
        .ex_op_i   (ex_op),
        .ex_a_i    (ex_a),
        .ex_b_i    (ex_b),
        .ex_imm_i  (ex_imm),
        .alu_res_o (alu_res)
    );

    branch_unit u_branch_unit (
        .ex_op_i     (ex_op),
        .ex_pc_i     (ex_pc),
        .ex_imm_i    (ex_imm),
        .ex_a_i      (ex_a),
        .ex_b_i      (ex_b),
        .br_taken_o  (br_taken),
        .br_target_o (br_target),
        .br_link_o   (br_link)
    );

    exec_writeback u_exec_writeback (
        .clk,
        .rst_n_i,
        .ex_valid_i    (ex_valid),
        .ex_op_i       (ex_op),
        .ex_tag_i      (ex_tag),
        .alu_res_i     (alu_res),
        .br_taken_i    (br_taken),
        .br_target_i   (br_target),
        .br_link_i     (br_link),
        .fifo_credit_i,
        .issue_allow_o (issue_allow),
        .result_valid_o,
        .result_tag_o,
        .result_data_o,
        .redirect_o,
        .redirect_pc_o
    );

endmodule

/* alu_iq/iq_select.sv */
module iq_select (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        flush_i,
    input  logic                        disp_valid_i,
    input  iq_pkg::iq_op_e              disp_op_i,
    input  logic [iq_pkg::XLEN-1:0]     disp_pc_i,
    input  logic [iq_pkg::XLEN-1:0]     disp_imm_i,
    input  logic [iq_pkg::TAG_W-1:0]    disp_dst_tag_i,
    input  logic                        disp_src0_rdy_i,
    input  logic [iq_pkg::TAG_W-1:0]    disp_src0_tag_i,
    input  logic [iq_pkg::XLEN-1:0]     disp_src0_val_i,
    input  logic                        disp_src1_rdy_i,
    input  logic [iq_pkg::TAG_W-1:0]    disp_src1_tag_i,
    input  logic [iq_pkg::XLEN-1:0]     disp_src1_val_i,
    input  logic                        wb_valid_i,
    input  logic [iq_pkg::TAG_W-1:0]    wb_tag_i,
    input  logic [iq_pkg::XLEN-1:0]     wb_data_i,
    input  logic                        fb_valid_i,
    input  logic [iq_pkg::TAG_W-1:0]    fb_tag_i,
    input  logic [iq_pkg::XLEN-1:0]     fb_data_i,
    input  logic                        issue_allow_i,
    output logic                        iq_credit_o,
    output logic                        ex_valid_o,
    output iq_pkg::iq_op_e              ex_op_o,
    output logic [iq_pkg::XLEN-1:0]     ex_pc_o,
    output logic [iq_pkg::XLEN-1:0]     ex_imm_o,
    output logic [iq_pkg::XLEN-1:0]     ex_a_o,
    output logic [iq_pkg::XLEN-1:0]     ex_b_o,
    output logic [iq_pkg::TAG_W-1:0]    ex_tag_o
);
    import iq_pkg::*;

    // entry state
    logic [IQ_DEPTH-1:0] ent_valid;
    logic [AGE_W-1:0]    ent_age [IQ_DEPTH];
    iq_op_e              ent_op  [IQ_DEPTH];
    logic [XLEN-1:0]     ent_pc  [IQ_DEPTH];
    logic [XLEN-1:0]     ent_imm [IQ_DEPTH];
    logic [TAG_W-1:0]    ent_dst [IQ_DEPTH];
    logic [1:0]          src_rdy [IQ_DEPTH];
    logic [TAG_W-1:0]    src_tag [IQ_DEPTH][2];
    logic [XLEN-1:0]     src_val [IQ_DEPTH][2];

    // dispatch sources as arrays
    logic [1:0]          disp_rdy;
    logic [TAG_W-1:0]    disp_tag [2];
    logic [XLEN-1:0]     disp_val [2];

    // snoop slots, the last one is the incoming dispatch
    logic [TAG_W-1:0]    snoop_tag  [IQ_DEPTH+1][2];
    logic                snoop_hit  [IQ_DEPTH+1][2];
    logic [XLEN-1:0]     snoop_data [IQ_DEPTH+1][2];

    logic [IQ_DEPTH-1:0] ent_rdy;
    logic [IQ_DEPTH-1:0] disp_sel;
    logic [IQ_DEPTH-1:0] issue_sel;
    logic [IDX_W-1:0]    issue_idx;
    logic                any_rdy;
    logic                issue_go;

    assign disp_rdy = {disp_src1_rdy_i, disp_src0_rdy_i};
    assign disp_tag = '{disp_src0_tag_i, disp_src1_tag_i};
    assign disp_val = '{disp_src0_val_i, disp_src1_val_i};

    // ------------------------------
    // wakeup snoop
    // ------------------------------
    always_comb begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            snoop_tag[i] = src_tag[i];
        end
        snoop_tag[IQ_DEPTH] = disp_tag;
    end

    // external bus wins if both carry the same tag
    always_comb begin
        for (int i = 0; i <= IQ_DEPTH; i++) begin
            for (int s = 0; s < 2; s++) begin
                snoop_hit[i][s]  = 1'b0;
                snoop_data[i][s] = wb_data_i;
                if (wb_valid_i && wb_tag_i == snoop_tag[i][s]) begin
                    snoop_hit[i][s] = 1'b1;
                end else if (fb_valid_i && fb_tag_i == snoop_tag[i][s]) begin
                    snoop_hit[i][s]  = 1'b1;
                    snoop_data[i][s] = fb_data_i;
                end
            end
        end
    end

    // ------------------------------
    // allocation and oldest-ready pick
    // ------------------------------
    always_comb begin
        disp_sel = '0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (!ent_valid[i]) begin
                disp_sel = '0;
                disp_sel[i] = disp_valid_i && !flush_i;
            end
        end
    end

    always_comb begin
        issue_idx = '0;
        any_rdy   = 1'b0;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            ent_rdy[i] = ent_valid[i] && (&src_rdy[i]);
            if (ent_rdy[i] && (!any_rdy || age_wins(ent_age[i], ent_age[issue_idx]))) begin
                issue_idx = IDX_W'(i);
                any_rdy   = 1'b1;
            end
        end
    end

    assign issue_go  = any_rdy && issue_allow_i && !flush_i;
    assign issue_sel = issue_go ? (IQ_DEPTH'(1) << issue_idx) : '0;

    // ------------------------------
    // entry update
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ent_valid <= '0;
            for (int i = 0; i < IQ_DEPTH; i++) begin
                ent_age[i] <= '0;
                src_rdy[i] <= '0;
            end
        end else if (flush_i) begin
            ent_valid <= '0;
        end else begin
            for (int i = 0; i < IQ_DEPTH; i++) begin
                if (issue_sel[i]) begin
                    ent_valid[i] <= 1'b0;
                end else if (disp_sel[i]) begin
                    ent_valid[i] <= 1'b1;
                    ent_age[i]   <= '0;
                    for (int s = 0; s < 2; s++) begin
                        src_rdy[i][s] <= disp_rdy[s] || snoop_hit[IQ_DEPTH][s];
                    end
                end else if (ent_valid[i]) begin
                    // waiting entries keep ageing, ready or not
                    ent_age[i] <= age_inc(ent_age[i]);
                    for (int s = 0; s < 2; s++) begin
                        if (snoop_hit[i][s]) begin
                            src_rdy[i][s] <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (disp_sel[i]) begin
                ent_op[i]  <= disp_op_i;
                ent_pc[i]  <= disp_pc_i;
                ent_imm[i] <= disp_imm_i;
                ent_dst[i] <= disp_dst_tag_i;
                for (int s = 0; s < 2; s++) begin
                    src_tag[i][s] <= disp_tag[s];
                    src_val[i][s] <= disp_rdy[s] ? disp_val[s] : snoop_data[IQ_DEPTH][s];
                end
            end else begin
                for (int s = 0; s < 2; s++) begin
                    if (!src_rdy[i][s] && snoop_hit[i][s]) begin
                        src_val[i][s] <= snoop_data[i][s];
                    end
                end
            end
        end
    end

    // ------------------------------
    // execute-stage registers
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_valid_o  <= 1'b0;
            iq_credit_o <= 1'b0;
        end else begin
            ex_valid_o  <= issue_go;
            iq_credit_o <= issue_go;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_go) begin
            ex_op_o  <= ent_op[issue_idx];
            ex_pc_o  <= ent_pc[issue_idx];
            ex_imm_o <= ent_imm[issue_idx];
            ex_a_o   <= src_val[issue_idx][0];
            ex_b_o   <= src_val[issue_idx][1];
            ex_tag_o <= ent_dst[issue_idx];
        end
    end

    // dispatcher credits must keep a full queue from seeing a dispatch
    a_no_disp_full: assert property (@(posedge clk) disable iff (!rst_n_i)
        disp_valid_i |-> !(&ent_valid));

    // only issue frees an entry outside of flush
    a_one_free: assert property (@(posedge clk) disable iff (!rst_n_i)
        !flush_i |=> $onehot0($past(ent_valid) & ~ent_valid));

endmodule

/* common/iq_pkg.sv */
package iq_pkg;

    // ------------------------------
    // widths and sizes
    // ------------------------------
    localparam int XLEN        = 32;
    localparam int TAG_W       = 5;
    localparam int IQ_DEPTH    = 4;
    localparam int AGE_W       = 4;
    localparam int OUT_CREDITS = 2;

    // entry index and output credit counter widths
    localparam int IDX_W = $clog2(IQ_DEPTH);
    localparam int CNT_W = $clog2(OUT_CREDITS + 1);

    localparam logic [AGE_W-1:0] AGE_MAX = '1;

    // ------------------------------
    // opcodes
    // ------------------------------
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,
        OP_SRL  = 4'd6,
        OP_SRA  = 4'd7,
        OP_SLT  = 4'd8,
        OP_SLTU = 4'd9,
        OP_LUI  = 4'd10,
        OP_BEQ  = 4'd11,
        OP_BNE  = 4'd12,
        OP_BLT  = 4'd13,
        OP_JAL  = 4'd14,
        OP_JALR = 4'd15
    } iq_op_e;

    // conditional branches and both jumps
    function automatic logic is_branch_op(input iq_op_e op);
        return op inside {OP_BEQ, OP_BNE, OP_BLT, OP_JAL, OP_JALR};
    endfunction

    // ------------------------------
    // age state
    // ------------------------------
    // one step older, held at the top
    function automatic logic [AGE_W-1:0] age_inc(input logic [AGE_W-1:0] age);
        return (age == AGE_MAX) ? age : age + 1'b1;
    endfunction

    // strictly older only, so a tie keeps the lower index
    function automatic logic age_wins(input logic [AGE_W-1:0] cand,
                                      input logic [AGE_W-1:0] best);
        return cand > best;
    endfunction

endpackage

/* rtl/branch_unit.sv */
module branch_unit (
    input  iq_pkg::iq_op_e              ex_op_i,
    input  logic [iq_pkg::XLEN-1:0]     ex_pc_i,
    input  logic [iq_pkg::XLEN-1:0]     ex_imm_i,
    input  logic [iq_pkg::XLEN-1:0]     ex_a_i,
    input  logic [iq_pkg::XLEN-1:0]     ex_b_i,
    output logic                        br_taken_o,
    output logic [iq_pkg::XLEN-1:0]     br_target_o,
    output logic [iq_pkg::XLEN-1:0]     br_link_o
);
    import iq_pkg::*;

    logic cond;

    always_comb begin
        case (ex_op_i)
            OP_BEQ:           cond = ex_a_i == ex_b_i;
            OP_BNE:           cond = ex_a_i != ex_b_i;
            OP_BLT:           cond = $signed(ex_a_i) < $signed(ex_b_i);
            OP_JAL, OP_JALR:  cond = 1'b1;
            default:          cond = 1'b0;
        endcase
    end

    assign br_taken_o = is_branch_op(ex_op_i) && cond;

    // register-relative jump drops bit 0
    assign br_target_o = (ex_op_i == OP_JALR) ? ((ex_a_i + ex_imm_i) & ~XLEN'(1))
                                              : (ex_pc_i + ex_imm_i);

    assign br_link_o = ex_pc_i + XLEN'(4);

endmodule

/* rtl/exec_writeback.sv */
module exec_writeback (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        ex_valid_i,
    input  iq_pkg::iq_op_e              ex_op_i,
    input  logic [iq_pkg::TAG_W-1:0]    ex_tag_i,
    input  logic [iq_pkg::XLEN-1:0]     alu_res_i,
    input  logic                        br_taken_i,
    input  logic [iq_pkg::XLEN-1:0]     br_target_i,
    input  logic [iq_pkg::XLEN-1:0]     br_link_i,
    input  logic                        fifo_credit_i,
    output logic                        issue_allow_o,
    output logic                        result_valid_o,
    output logic [iq_pkg::TAG_W-1:0]    result_tag_o,
    output logic [iq_pkg::XLEN-1:0]     result_data_o,
    output logic                        redirect_o,
    output logic [iq_pkg::XLEN-1:0]     redirect_pc_o
);
    import iq_pkg::*;

    logic [CNT_W-1:0] credit_cnt;
    logic [XLEN-1:0]  wb_data;
    logic             is_jump;

    // ------------------------------
    // output credits
    // ------------------------------
    // the instruction sitting in ex has already spent its credit
    assign issue_allow_o = credit_cnt > CNT_W'(ex_valid_i);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            credit_cnt <= CNT_W'(OUT_CREDITS);
        end else begin
            credit_cnt <= credit_cnt - CNT_W'(ex_valid_i) + CNT_W'(fifo_credit_i);
        end
    end

    // ------------------------------
    // result merge
    // ------------------------------
    assign is_jump = ex_op_i inside {OP_JAL, OP_JALR};

    always_comb begin
        if (is_jump) begin
            wb_data = br_link_i;
        end else if (is_branch_op(ex_op_i)) begin
            wb_data = '0;
        end else begin
            wb_data = alu_res_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            result_valid_o <= 1'b0;
            redirect_o     <= 1'b0;
        end else begin
            result_valid_o <= ex_valid_i;
            redirect_o     <= ex_valid_i && is_branch_op(ex_op_i) && br_taken_i;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid_i) begin
            result_tag_o  <= ex_tag_i;
            result_data_o <= wb_data;
            redirect_pc_o <= br_target_i;
        end
    end

    // FIFO never hands back more than it was given
    a_credit_max: assert property (@(posedge clk) disable iff (!rst_n_i)
        fifo_credit_i |=> credit_cnt <= CNT_W'(OUT_CREDITS));

endmodule

/* rtl/int_alu.sv */
module int_alu (
    input  iq_pkg::iq_op_e              ex_op_i,
    input  logic [iq_pkg::XLEN-1:0]     ex_a_i,
    input  logic [iq_pkg::XLEN-1:0]     ex_b_i,
    input  logic [iq_pkg::XLEN-1:0]     ex_imm_i,
    output logic [iq_pkg::XLEN-1:0]     alu_res_o
);
    import iq_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    // shift amount from the low bits of b
    assign shamt = ex_b_i[4:0];
    assign lt_s  = $signed(ex_a_i) < $signed(ex_b_i);
    assign lt_u  = ex_a_i < ex_b_i;

    always_comb begin
        unique case (ex_op_i)
            OP_ADD:  alu_res_o = ex_a_i + ex_b_i;
            OP_SUB:  alu_res_o = ex_a_i - ex_b_i;
            OP_AND:  alu_res_o = ex_a_i & ex_b_i;
            OP_OR:   alu_res_o = ex_a_i | ex_b_i;
            OP_XOR:  alu_res_o = ex_a_i ^ ex_b_i;
            OP_SLL:  alu_res_o = ex_a_i << shamt;
            OP_SRL:  alu_res_o = ex_a_i >> shamt;
            OP_SRA:  alu_res_o = XLEN'($signed(ex_a_i) >>> shamt);
            OP_SLT:  alu_res_o = XLEN'(lt_s);
            OP_SLTU: alu_res_o = XLEN'(lt_u);
            OP_LUI:  alu_res_o = ex_imm_i;
            // branch opcodes take their value from the branch unit
            default: alu_res_o = '0;
        endcase
    end

endmodule

/* tests/alu_iq_vectors.svh */
// columns: test, mode, opcode, pc, imm, dst tag, src0 ready, src0 value or producer tag,
//          src1 ready, src1 value or producer tag, wakeup delay, expected data
`ifndef ALU_IQ_VECTORS_SVH
`define ALU_IQ_VECTORS_SVH

// row modes
localparam logic [2:0] M_NORM    = 3'd0;
localparam logic [2:0] M_DRAIN   = 3'd1;
localparam logic [2:0] M_HOLD    = 3'd2;
localparam logic [2:0] M_RELEASE = 3'd3;
localparam logic [2:0] M_KILL    = 3'd4;
localparam logic [2:0] M_FLUSH   = 3'd5;

typedef struct packed {
    logic [3:0]  test;
    logic [2:0]  mode;
    iq_op_e      op;
    logic [31:0] pc;
    logic [31:0] imm;
    logic [4:0]  dst;
    logic        r0;
    logic [31:0] v0;
    logic        r1;
    logic [31:0] v1;
    logic [3:0]  wake;
    logic [31:0] exp;
} vec_row_t;

localparam int N_ROWS = 31;

localparam vec_row_t VEC [N_ROWS] = '{
    '{1, M_DRAIN,   OP_ADD,  'h100, 0, 1, 1, 5, 1, 7, 0, 'hC},
    '{1, M_NORM,    OP_SUB,  'h104, 0, 2, 1, 5, 1, 7, 0, 'hFFFF_FFFE},
    '{1, M_NORM,    OP_AND,  'h108, 0, 3, 1, 'hF0F0_00FF, 1, 'h0FF0_0F0F, 0, 'h00F0_000F},
    '{1, M_NORM,    OP_OR,   'h10C, 0, 4, 1, 'hF000_0000, 1, 'h0000_00A5, 0, 'hF000_00A5},
    '{1, M_NORM,    OP_XOR,  'h110, 0, 5, 1, 'hFFFF_0000, 1, 'h0F0F_0F0F, 0, 'hF0F0_0F0F},
    '{1, M_NORM,    OP_SLL,  'h114, 0, 6, 1, 3, 1, 'h21, 0, 6},
    '{1, M_NORM,    OP_SRL,  'h118, 0, 7, 1, 'h8000_0000, 1, 4, 0, 'h0800_0000},
    '{1, M_NORM,    OP_SRA,  'h11C, 0, 8, 1, 'h8000_0000, 1, 4, 0, 'hF800_0000},
    '{1, M_NORM,    OP_SLT,  'h120, 0, 9, 1, 'hFFFF_FFFF, 1, 1, 0, 1},
    '{1, M_NORM,    OP_SLTU, 'h124, 0, 10, 1, 'hFFFF_FFFF, 1, 1, 0, 0},
    '{1, M_NORM,    OP_LUI,  'h128, 'h1234_5000, 11, 1, 0, 1, 0, 0, 'h1234_5000},
    '{2, M_DRAIN,   OP_BEQ,  'h200, 'h40, 1, 1, 9, 1, 9, 0, 0},
    '{2, M_NORM,    OP_BNE,  'h204, 'h10, 2, 1, 9, 1, 9, 0, 0},
    '{2, M_NORM,    OP_BLT,  'h208, 'hFFFF_FFF0, 3, 1, 'hFFFF_FFFE, 1, 3, 0, 0},
    '{2, M_NORM,    OP_JAL,  'h20C, 'h100, 4, 1, 0, 1, 0, 0, 'h210},
    '{2, M_NORM,    OP_JALR, 'h210, 7, 5, 1, 'h1000, 1, 0, 0, 'h214},
    '{3, M_DRAIN,   OP_ADD,  'h300, 0, 12, 1, 'h10, 0, 28, 3, 'h1C10},
    '{3, M_NORM,    OP_SUB,  'h304, 0, 13, 0, 12, 1, 'h10, 0, 'h1C00},
    '{3, M_NORM,    OP_XOR,  'h308, 0, 14, 0, 13, 0, 29, 1, 'h0100},
    '{3, M_NORM,    OP_ADD,  'h30C, 0, 15, 0, 30, 1, 1, 0, 'h1E01},
    '{4, M_HOLD,    OP_ADD,  'h400, 0, 16, 1, 1, 1, 1, 0, 2},
    '{4, M_NORM,    OP_ADD,  'h404, 0, 17, 1, 2, 1, 2, 0, 4},
    '{4, M_NORM,    OP_ADD,  'h408, 0, 18, 1, 3, 1, 3, 0, 6},
    '{4, M_RELEASE, OP_OR,   'h40C, 0, 19, 1, 'h10, 1, 1, 0, 'h11},
    '{5, M_DRAIN,   OP_ADD,  'h500, 0, 20, 1, 'h7FFF_FFFF, 1, 1, 0, 'h8000_0000},
    '{6, M_KILL,    OP_ADD,  'h600, 0, 21, 0, 31, 1, 1, 4, 0},
    '{6, M_KILL,    OP_SUB,  'h604, 0, 22, 0, 31, 1, 1, 4, 0},
    '{6, M_FLUSH,   OP_ADD,  'h608, 0, 23, 1, 10, 1, 20, 0, 'h1E},
    '{6, M_NORM,    OP_AND,  'h60C, 0, 24, 1, 'hFF, 1, 'h0F, 0, 'h0F},
    '{6, M_NORM,    OP_SLL,  'h610, 0, 25, 1, 1, 1, 5, 0, 'h20},
    '{6, M_NORM,    OP_ADD,  'h614, 0, 26, 0, 25, 1, 'h100, 0, 'h120}
};

`endif

/* tests/tb_alu_iq.sv */
module tb_alu_iq;
    timeunit 1ns;
    timeprecision 100ps;
    import iq_pkg::*;

    `include "alu_iq_vectors.svh"

    localparam int TIMEOUT = 300;

    logic clk = 1'b0;
    logic rst_n_i, flush_i, disp_valid_i, wb_valid_i, fifo_credit_i;
    iq_op_e disp_op_i;
    logic [XLEN-1:0] disp_pc_i, disp_imm_i, disp_src0_val_i, disp_src1_val_i, wb_data_i;
    logic [TAG_W-1:0] disp_dst_tag_i, disp_src0_tag_i, disp_src1_tag_i, wb_tag_i;
    logic disp_src0_rdy_i, disp_src1_rdy_i;
    logic iq_credit_o, result_valid_o, redirect_o;
    logic [TAG_W-1:0] result_tag_o;
    logic [XLEN-1:0] result_data_o, redirect_pc_o;

    // reference state, keyed by destination tag
    logic [XLEN-1:0] exp_data [32];
    logic [XLEN-1:0] exp_rpc [32];
    logic exp_redir [32];
    logic exp_live [32];
    int exp_test [32];
    int exp_lat [32];
    int exp_min [32];

    int cyc = 0, disp_credits = IQ_DEPTH, expected_cnt = 0, results = 0;
    int returned = 0, iq_pulses = 0, hold_base = 0, tot_chk = 0, tot_err = 0;
    int chk [8];
    int errs [8];
    logic withhold = 1'b0, timed_out = 1'b0;
    string timeout_what;
    logic [31:0] lfsr = 32'h5497;
    int fifo_due [$];
    int wb_due [$];
    logic [TAG_W-1:0] wb_tag_q [$];
    string test_name [8] = '{"", "alu opcodes", "branches and jumps", "operand wakeup",
                             "credit balance", "fixed latency", "flush", ""};

    alu_iq DUT (.*);

    always #2 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic int take_bits(input int n);
        int r;
        r = 0;
        for (int k = 0; k < n; k++) begin
            r = (r << 1) | lfsr[0];
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [XLEN-1:0] wake_value(input logic [TAG_W-1:0] tag);
        return XLEN'(tag) * 32'h100;
    endfunction

    // expected behaviour of one instruction
    task automatic ref_exec(input iq_op_e op, input logic [31:0] pc, imm, a, b,
                            output logic [31:0] d, output logic taken,
                            output logic [31:0] tgt);
        d = '0;
        taken = 1'b0;
        tgt = (op == OP_JALR) ? ((a + imm) & 32'hFFFF_FFFE) : (pc + imm);
        case (op)
            OP_ADD:  d = a + b;
            OP_SUB:  d = a - b;
            OP_AND:  d = a & b;
            OP_OR:   d = a | b;
            OP_XOR:  d = a ^ b;
            OP_SLL:  d = a << b[4:0];
            OP_SRL:  d = a >> b[4:0];
            OP_SRA:  d = $unsigned($signed(a) >>> b[4:0]);
            OP_SLT:  d = {31'b0, $signed(a) < $signed(b)};
            OP_SLTU: d = {31'b0, a < b};
            OP_LUI:  d = imm;
            OP_BEQ:  taken = (a == b);
            OP_BNE:  taken = (a != b);
            OP_BLT:  taken = ($signed(a) < $signed(b));
            default: begin
                taken = 1'b1;
                d = pc + 4;
            end
        endcase
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // a hung wait blocks here and the watchdog process ends the run
    task automatic hang(input string what);
        timeout_what = what;
        timed_out = 1'b1;
        wait (1'b0);
    endtask

    initial begin
        wait (timed_out);
        $display("timeout while waiting for %s at %0t", timeout_what, $time);
        $display("CHECKS FAILED");
        $finish;
    end

    // ------------------------------
    // result monitor
    // ------------------------------
    task automatic check_result();
        int t, dly;
        logic [TAG_W-1:0] tag;
        tag = result_tag_o;
        t = exp_test[tag];
        results++;
        assert (exp_live[tag]) else begin
            $display("%0t: result appeared for tag %0d, which is not outstanding", $time, tag);
            tot_err++;
        end
        assert (results <= OUT_CREDITS + returned) else begin
            $display("%0t: more results than output credits allow", $time);
            tot_err++;
        end
        tot_chk += 2;
        if (exp_live[tag]) begin
            exp_live[tag] = 1'b0;
            chk[t] += 3;
            assert (result_data_o == exp_data[tag]) else begin
                $display("error %0t result_data_o: got %h expected %h", $time,
                         result_data_o, exp_data[tag]);
                errs[t]++;
            end
            assert (redirect_o == exp_redir[tag]) else begin
                $display("error %0t redirect_o: got %b expected %b", $time,
                         redirect_o, exp_redir[tag]);
                errs[t]++;
            end
            assert (exp_lat[tag] < 0 ? cyc >= exp_min[tag] : cyc == exp_lat[tag]) else begin
                $display("error %0t result_valid_o cycle: got %0d expected %0d", $time,
                         cyc, exp_lat[tag] < 0 ? exp_min[tag] : exp_lat[tag]);
                errs[t]++;
            end
            if (exp_redir[tag]) begin
                chk[t]++;
                assert (redirect_pc_o == exp_rpc[tag]) else begin
                    $display("error %0t redirect_pc_o: got %h expected %h", $time,
                             redirect_pc_o, exp_rpc[tag]);
                    errs[t]++;
                end
            end
        end
        dly = take_bits(2);
        fifo_due.push_back(cyc + dly);
    endtask

    always @(negedge clk) begin
        if (rst_n_i) begin
            if (iq_credit_o) begin
                disp_credits++;
                iq_pulses++;
            end
            if (result_valid_o) begin
                check_result();
            end
        end
    end

    // FIFO credit returns and external wakeup broadcasts
    always @(posedge clk) begin
        #1;
        fifo_credit_i = 1'b0;
        wb_valid_i = 1'b0;
        if (!withhold && fifo_due.size() > 0 && fifo_due[0] <= cyc) begin
            void'(fifo_due.pop_front());
            fifo_credit_i = 1'b1;
            returned++;
        end
        if (wb_due.size() > 0 && wb_due[0] <= cyc) begin
            void'(wb_due.pop_front());
            wb_tag_i = wb_tag_q.pop_front();
            wb_data_i = wake_value(wb_tag_i);
            wb_valid_i = 1'b1;
        end
    end

    task automatic drain();
        int waited;
        waited = 0;
        while (results != expected_cnt || returned != results) begin
            step();
            waited++;
            if (waited > TIMEOUT) hang("outstanding results to drain");
        end
    endtask

    // ------------------------------
    // dispatch of one table row
    // ------------------------------
    task automatic dispatch_row(input int i);
        int waited;
        logic [31:0] a, b, d, tgt;
        logic taken;
        vec_row_t r;
        r = VEC[i];
        waited = 0;
        while (disp_credits == 0) begin
            step();
            waited++;
            if (waited > TIMEOUT) hang("a dispatch credit");
        end
        a = r.r0 ? r.v0 : (r.v0 >= 28 ? wake_value(r.v0[4:0]) : exp_data[r.v0[4:0]]);
        b = r.r1 ? r.v1 : (r.v1 >= 28 ? wake_value(r.v1[4:0]) : exp_data[r.v1[4:0]]);
        ref_exec(r.op, r.pc, r.imm, a, b, d, taken, tgt);
        if (r.mode != M_KILL) begin
            chk[r.test]++;
            assert (d == r.exp) else begin
                $display("table row %0d disagrees with the reference model", i);
                errs[r.test]++;
            end
            exp_data[r.dst] = d;
            exp_redir[r.dst] = taken;
            exp_rpc[r.dst] = tgt;
            exp_live[r.dst] = 1'b1;
            exp_test[r.dst] = r.test;
            exp_lat[r.dst] = (r.mode == M_DRAIN && r.r0 && r.r1) ? cyc + 3 : -1;
            exp_min[r.dst] = cyc + 3;
            expected_cnt++;
            if ((!r.r0 && r.v0 >= 28) || (!r.r1 && r.v1 >= 28)) begin
                exp_min[r.dst] = cyc + r.wake + 3;
            end
        end
        // sources fed from the external bus, flushed rows included
        if (!r.r0 && r.v0 >= 28) begin
            wb_due.push_back(cyc + r.wake);
            wb_tag_q.push_back(r.v0[4:0]);
        end
        if (!r.r1 && r.v1 >= 28) begin
            wb_due.push_back(cyc + r.wake);
            wb_tag_q.push_back(r.v1[4:0]);
        end
        disp_op_i = r.op;
        disp_pc_i = r.pc;
        disp_imm_i = r.imm;
        disp_dst_tag_i = r.dst;
        disp_src0_rdy_i = r.r0;
        disp_src0_tag_i = r.r0 ? '0 : r.v0[4:0];
        disp_src0_val_i = r.r0 ? r.v0 : '0;
        disp_src1_rdy_i = r.r1;
        disp_src1_tag_i = r.r1 ? '0 : r.v1[4:0];
        disp_src1_val_i = r.r1 ? r.v1 : '0;
        disp_valid_i = 1'b1;
        disp_credits--;
        step();
        disp_valid_i = 1'b0;
    endtask

    task automatic report_test(input int t);
        $display("test %0d %s: %0d checks, %0d errors", t, test_name[t], chk[t], errs[t]);
        tot_chk += chk[t];
        tot_err += errs[t];
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        rst_n_i = 1'b0;
        flush_i = 1'b0;
        disp_valid_i = 1'b0;
        disp_op_i = OP_ADD;
        {disp_pc_i, disp_imm_i, disp_src0_val_i, disp_src1_val_i} = '0;
        {disp_dst_tag_i, disp_src0_tag_i, disp_src1_tag_i} = '0;
        {disp_src0_rdy_i, disp_src1_rdy_i} = '0;
        wb_valid_i = 1'b0;
        wb_tag_i = '0;
        wb_data_i = '0;
        fifo_credit_i = 1'b0;
        for (int k = 0; k < 32; k++) begin
            exp_live[k] = 1'b0;
            exp_data[k] = '0;
        end
        for (int k = 0; k < 8; k++) begin
            chk[k] = 0;
            errs[k] = 0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        chk[5]++;
        assert (!result_valid_o && !redirect_o && !iq_credit_o) else begin
            $display("outputs are not low after reset");
            errs[5]++;
        end

        for (int i = 0; i < N_ROWS; i++) begin
            if (i > 0 && VEC[i].test != VEC[i-1].test) begin
                drain();
                report_test(VEC[i-1].test);
            end
            case (VEC[i].mode)
                M_DRAIN: drain();
                M_HOLD: begin
                    drain();
                    withhold = 1'b1;
                    hold_base = results;
                end
                M_RELEASE: begin
                    repeat (10) step();
                    chk[4]++;
                    assert (results == hold_base + OUT_CREDITS) else begin
                        $display("error %0t result count under back-pressure: got %0d expected %0d",
                                 $time, results - hold_base, OUT_CREDITS);
                        errs[4]++;
                    end
                    withhold = 1'b0;
                end
                M_FLUSH: begin
                    drain();
                    flush_i = 1'b1;
                    step();
                    flush_i = 1'b0;
                    disp_credits = IQ_DEPTH;
                end
                default: ;
            endcase
            dispatch_row(i);
        end
        drain();
        // flushed tags must stay silent
        repeat (12) step();
        tot_chk++;
        assert (iq_pulses == results) else begin
            $display("error %0t iq_credit_o pulses: got %0d expected %0d", $time,
                     iq_pulses, results);
            tot_err++;
        end
        report_test(VEC[N_ROWS-1].test);
        $display("total: %0d checks, %0d errors", tot_chk, tot_err);
        if (tot_err == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+tests
common/iq_pkg.sv
rtl/int_alu.sv
rtl/branch_unit.sv
rtl/exec_writeback.sv
alu_iq/iq_select.sv
alu_iq/alu_iq.sv
tests/tb_alu_iq.sv
